// ==== verif/bus_trace.txt ====
// op_addr_data_mode per line: op 1 is write and 0 is read, addr is 15 bits in 4 hex digits
// data is the byte written or returned by the slave, mode 1 withholds the first address ack
1_2A5F_C3_0
0_2A5F_3C_0
1_7FFF_FF_0
0_0001_01_0
1_5555_AA_0
0_2AAA_55_0
1_1234_80_1
0_4321_7E_1
1_0F0F_00_0
0_70F0_FF_0
1_3C3C_5A_0
0_0000_A5_0

// ==== sim.f ====
verilog/bus_master_pkg.sv
verilog/serial_shifter.sv
verilog/master_ctrl.sv
verilog/bus_master.sv
verif/tb_clock_gen.sv
verif/tb_bus_master.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_bus_master -o tb_bus_master_sim

out=$(./obj_dir/tb_bus_master_sim)
echo "$out"

if echo "$out" | grep -qx "Test passed"
then
    exit 0
fi
exit 1

// ==== verif/tb_bus_master.sv ====
`timescale 1ns/1ps

module tb_bus_master;
    import bus_master_pkg::*;

    localparam int WAIT_LIMIT  = 100;                        // Cycles allowed for any single wait
    localparam int GRANT_DELAY = 3;
    localparam int TRACE_DEPTH = 32;

    localparam int SIG_RSTN    = 0;
    localparam int SIG_REQUEST = 1;
    localparam int SIG_UTIL    = 2;
    localparam int SIG_SDO_EN  = 3;
    localparam int SIG_DVALID  = 4;

    logic                  clk;
    logic                  rstn;
    logic                  hold;
    logic                  execute;
    master_cmd_t           cmd;
    logic                  grant;
    logic                  sdi;
    logic                  busy;
    logic                  dvalid;
    logic [DATA_WIDTH-1:0] rdata;
    bus_drive_t            bus;

    logic [31:0]           trace_mem [0:TRACE_DEPTH-1];      // op, addr, data, ack mode
    logic [15:0]           collected;                        // Right aligned bits seen on sdo
    int                    pass_count;
    int                    fail_count;
    bit                    timed_out;
    int                    req_age;

    tb_clock_gen clk_gen0 (
        .clk  (clk),
        .rstn (rstn)
    );

    bus_master dut0 (
        .clk     (clk),
        .rstn    (rstn),
        .hold    (hold),
        .execute (execute),
        .cmd     (cmd),
        .grant   (grant),
        .sdi     (sdi),
        .busy    (busy),
        .dvalid  (dvalid),
        .rdata   (rdata),
        .bus     (bus)
    );

    task automatic step();
        @(posedge clk);
        #1;                                                  // Outputs settled and inputs change here
    endtask

    function automatic logic probe(input int id);
        case (id)
            SIG_RSTN:    return rstn;
            SIG_REQUEST: return bus.request;
            SIG_UTIL:    return bus.utilizing;
            SIG_SDO_EN:  return bus.sdo_en;
            default:     return dvalid;
        endcase
    endfunction

    task automatic wait_for(input int id, input logic level, input string name);
        int n;
        n = 0;
        if (!timed_out)
        begin
            while (probe(id) !== level && n < WAIT_LIMIT)
            begin
                step();
                n++;
            end
            if (probe(id) !== level)
            begin
                $display("timeout at %0t: %s did not reach %0b within %0d cycles",
                         $time, name, level, WAIT_LIMIT);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic check_val(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
        if (!timed_out)
        begin
            assert (actual === expected)
            begin
                pass_count++;
            end
            else
            begin
                $display("mismatch at %0t: %s expected %0h actual %0h",
                         $time, name, expected, actual);
                fail_count++;
            end
        end
    endtask

    // Slave drives MSB first from a left aligned word
    task automatic drive_serial(input logic [15:0] bits, input int count);
        logic [15:0] rest;
        rest = bits;
        repeat (count)
        begin
            sdi  = rest[15];
            rest = {rest[14:0], 1'b0};
            step();
        end
        sdi = 1'b1;                                          // Slave silent again
    endtask

    task automatic collect_bits(input int count, input string name);
        collected = '0;
        wait_for(SIG_SDO_EN, 1'b1, name);
        repeat (count)
        begin
            collected = {collected[14:0], bus.sdo};
            step();
        end
        check_val("sdo_en after last bit", 16'd0, 16'(bus.sdo_en));
    endtask

    task automatic run_entry(input int idx, input logic [31:0] entry);
        logic                  is_write;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        logic                  withhold;
        int                    errors_before;
        string                 op_name;

        is_write      = entry[28];
        addr          = entry[26:12];
        data          = entry[11:4];
        withhold      = entry[0];
        errors_before = fail_count;
        if (is_write)
            op_name = "write";
        else
            op_name = "read";

        wait_for(SIG_UTIL, 1'b1, "utilizing before execute");
        cmd     = '{rw: is_write, address: addr, wdata: data};
        execute = 1'b1;
        step();
        execute = 1'b0;
        collect_bits(ADDR_WIDTH, "sdo_en for address");
        check_val("address", 16'(addr), collected);
        check_val("rw", 16'(is_write), 16'(bus.rw));
        check_val("busy", 16'd1, 16'(busy));

        if (withhold)
        begin
            wait_for(SIG_REQUEST, 1'b0, "request release in ack wait");
            check_val("utilizing in release", 16'd0, 16'(bus.utilizing));
            wait_for(SIG_REQUEST, 1'b1, "request after timeout");
            collect_bits(ADDR_WIDTH, "sdo_en for resent address");
            check_val("resent address", 16'(addr), collected);
        end

        if (is_write)
        begin
            drive_serial({3'b100, 13'd0}, 3);                // Gap bit then ack 0 0
            collect_bits(DATA_WIDTH, "sdo_en for write data");
            check_val("write data", 16'(data), collected);
            drive_serial({3'b101, 13'd0}, 3);                // Gap bit then 0 1
        end
        else
        begin
            drive_serial({3'b100, 2'b01, data, 3'b000}, 13); // Ack then start prefix and byte
        end

        wait_for(SIG_DVALID, 1'b1, "dvalid");
        check_val("busy at dvalid", 16'd0, 16'(busy));
        if (!is_write)
            check_val("rdata", 16'(data), 16'(rdata));
        step();
        check_val("dvalid after pulse", 16'd0, 16'(dvalid));

        if (timed_out)
            $display("entry %0d %s addr %h: stopped by a timeout", idx, op_name, addr);
        else
            $display("entry %0d %s addr %h data %h ack mode %0d: %0d errors",
                     idx, op_name, addr, data, withhold, fail_count - errors_before);
    endtask

    // Arbiter grants a few cycles after request rises
    initial
    begin
        grant   = 1'b0;
        req_age = 0;
        forever
        begin
            step();
            if (rstn && bus.request)
                req_age++;
            else
                req_age = 0;
            grant = (req_age >= GRANT_DELAY);
        end
    end

    initial
    begin
        int idx;
        hold       = 1'b0;
        execute    = 1'b0;
        cmd        = '0;
        sdi        = 1'b1;
        pass_count = 0;
        fail_count = 0;
        timed_out  = 1'b0;
        collected  = '0;
        for (idx = 0; idx < TRACE_DEPTH; idx++)
            trace_mem[idx] = {4'hF, 28'(idx)};               // Op nibble F ends the trace
        $readmemh("verif/bus_trace.txt", trace_mem);

        wait_for(SIG_RSTN, 1'b1, "reset release");
        step();
        check_val("request after reset", 16'd0, 16'(bus.request));
        check_val("utilizing after reset", 16'd0, 16'(bus.utilizing));
        check_val("busy after reset", 16'd0, 16'(busy));
        check_val("dvalid after reset", 16'd0, 16'(dvalid));
        check_val("sdo_en after reset", 16'd0, 16'(bus.sdo_en));
        hold = 1'b1;
        step();                                              // Request follows hold on the next edge
        check_val("request after hold", 16'd1, 16'(bus.request));
        $display("reset and request: %0d errors", fail_count);

        idx = 0;
        while (idx < TRACE_DEPTH && trace_mem[idx][31:28] != 4'hF)
        begin
            run_entry(idx, trace_mem[idx]);
            idx++;
        end

        hold = 1'b0;
        step();                                              // Granted state releases one cycle later
        check_val("request after hold drop", 16'd0, 16'(bus.request));
        check_val("utilizing after hold drop", 16'd0, 16'(bus.utilizing));
        $display("hold drop: %0s", timed_out ? "stopped by a timeout" : "done");

        $display("checks passed %0d, checks failed %0d", pass_count, fail_count);
        if (fail_count == 0 && !timed_out)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rstn
);
    localparam int HALF_PERIOD  = 2;                         // 4 ns period
    localparam int RESET_CYCLES = 16;

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial
    begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rstn = 1'b1;                                      // Release away from the edge
    end

endmodule

// ==== verilog/bus_master.sv ====
`timescale 1ns/1ps

module bus_master (
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic                                  hold,
    input  logic                                  execute,
    input  bus_master_pkg::master_cmd_t           cmd,
    input  logic                                  grant,
    input  logic                                  sdi,
    output logic                                  busy,
    output logic                                  dvalid,
    output logic [bus_master_pkg::DATA_WIDTH-1:0] rdata,
    output bus_master_pkg::bus_drive_t            bus
);
    import bus_master_pkg::*;

    bus_drive_t  bus_ctl;                                    // Control levels from the FSM
    shift_ctrl_t shift_ctrl;
    logic        sent;
    logic        received;
    logic        sdo;
    logic        sdo_en;

    master_ctrl ctrl0 (
        .clk      (clk),
        .rstn     (rstn),
        .hold     (hold),
        .execute  (execute),
        .cmd      (cmd),
        .grant    (grant),
        .sdi      (sdi),
        .sent     (sent),
        .received (received),
        .busy     (busy),
        .dvalid   (dvalid),
        .bus_ctl  (bus_ctl),
        .ctrl     (shift_ctrl)
    );

    serial_shifter shift0 (
        .clk      (clk),
        .rstn     (rstn),
        .ctrl     (shift_ctrl),
        .sdi      (sdi),
        .sdo      (sdo),
        .sdo_en   (sdo_en),
        .sent     (sent),
        .received (received),
        .rdata    (rdata)
    );

    // Serial lines come from the shifter
    assign bus = '{request:   bus_ctl.request,
                   utilizing: bus_ctl.utilizing,
                   rw:        bus_ctl.rw,
                   sdo:       sdo,
                   sdo_en:    sdo_en};

endmodule

// ==== verilog/master_ctrl.sv ====
`timescale 1ns/1ps

module master_ctrl (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         hold,
    input  logic                         execute,
    input  bus_master_pkg::master_cmd_t  cmd,
    input  logic                         grant,
    input  logic                         sdi,
    input  logic                         sent,
    input  logic                         received,
    output logic                         busy,
    output logic                         dvalid,
    output bus_master_pkg::bus_drive_t   bus_ctl,
    output bus_master_pkg::shift_ctrl_t  ctrl
);
    import bus_master_pkg::*;

    master_state_e         state;
    logic                  req;
    logic                  util;
    logic                  rw_reg;                           // Latched operation
    logic [ADDR_WIDTH-1:0] addr_reg;
    logic [DATA_WIDTH-1:0] wdata_reg;
    logic                  shift_load;
    logic                  shift_data_phase;
    logic                  shift_capture;
    logic                  ack_buf;                          // Previous sdi bit
    logic [TIMEOUT_LEN-1:0] timer;
    logic [1:0]            prefix;
    logic                  accept;

    assign prefix = {ack_buf, sdi};                          // Older bit on the left
    assign accept = (state == ST_GRANTED) && hold && grant && execute;

    // Idle levels of rw and utilizing are zero
    assign bus_ctl = '{request:   req,
                       utilizing: util,
                       rw:        util & rw_reg,
                       sdo:       1'b0,
                       sdo_en:    1'b0};

    assign ctrl = '{load:       shift_load,
                    data_phase: shift_data_phase,
                    capture:    shift_capture,
                    word:       shift_data_phase ?
                                {wdata_reg, {(ADDR_WIDTH-DATA_WIDTH){1'b0}}} : addr_reg};

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            addr_reg  <= cmd.address;
            wdata_reg <= cmd.wdata;
        end
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state            <= ST_IDLE;
            req              <= 1'b0;
            util             <= 1'b0;
            rw_reg           <= 1'b0;
            busy             <= 1'b0;
            dvalid           <= 1'b0;
            shift_load       <= 1'b0;
            shift_data_phase <= 1'b0;
            shift_capture    <= 1'b0;
            ack_buf          <= 1'b1;
            timer            <= '0;
        end
        else
        begin
            dvalid     <= 1'b0;                              // Strobes
            shift_load <= 1'b0;
            ack_buf    <= 1'b1;                              // Prefix buffer idles high
            timer      <= '0;
            case (state)
                ST_IDLE:
                begin
                    busy <= 1'b0;
                    util <= 1'b0;
                    req  <= hold;
                    if (hold)
                    begin
                        state <= ST_REQUESTED;
                    end
                end
                ST_REQUESTED:
                begin
                    if (!hold)
                    begin
                        req   <= 1'b0;
                        busy  <= 1'b0;
                        state <= ST_IDLE;
                    end
                    else if (grant)
                    begin
                        util  <= 1'b1;
                        busy  <= 1'b0;
                        state <= ST_GRANTED;
                    end
                    else
                    begin
                        busy <= 1'b1;                        // Waiting on the arbiter
                    end
                end
                ST_GRANTED:
                begin
                    shift_data_phase <= 1'b0;
                    if (!hold)
                    begin
                        req   <= 1'b0;
                        util  <= 1'b0;
                        busy  <= 1'b0;
                        state <= ST_IDLE;
                    end
                    else if (!grant)
                    begin
                        util  <= 1'b0;
                        busy  <= 1'b1;
                        state <= ST_REQUESTED;
                    end
                    else if (execute)
                    begin
                        rw_reg     <= cmd.rw;
                        busy       <= 1'b1;
                        shift_load <= 1'b1;                  // Address out next
                        state      <= ST_ADDR_SEND;
                    end
                end
                ST_ADDR_SEND:
                begin
                    if (sent)
                    begin
                        state <= ST_ADDR_ACK_WAIT;
                    end
                end
                ST_ADDR_ACK_WAIT:
                begin
                    ack_buf <= sdi;
                    timer   <= timer + 1'b1;
                    if (timer == '1)
                    begin
                        req   <= 1'b1;                       // Retry
                        state <= ST_TIMEOUT;
                    end
                    else if (timer[TIMEOUT_LEN-1])
                    begin
                        req  <= 1'b0;                        // Release half
                        util <= 1'b0;
                    end
                    else
                    begin
                        req  <= 1'b1;
                        util <= 1'b1;
                        if (prefix == ADDR_ACK_PATTERN)
                        begin
                            ack_buf          <= 1'b1;
                            shift_data_phase <= 1'b1;
                            if (rw_reg)
                            begin
                                shift_load <= 1'b1;          // Write byte out next
                                state      <= ST_WRITE;
                            end
                            else
                            begin
                                state <= ST_READ_WAIT;
                            end
                        end
                    end
                end
                ST_TIMEOUT:
                begin
                    req  <= 1'b1;
                    util <= grant;
                    if (grant)
                    begin
                        shift_load <= 1'b1;                  // Resend the address
                        state      <= ST_ADDR_SEND;
                    end
                end
                ST_READ_WAIT:
                begin
                    util <= grant;
                    if (grant)
                    begin
                        ack_buf <= sdi;
                        if (prefix == DATA_ACK_PATTERN)
                        begin
                            shift_capture <= 1'b1;           // Start bit seen
                            state         <= ST_READ_DATA;
                        end
                    end
                end
                ST_READ_DATA:
                begin
                    if (received)
                    begin
                        shift_capture <= 1'b0;
                        dvalid        <= 1'b1;
                        busy          <= 1'b0;
                        state         <= ST_GRANTED;
                    end
                end
                ST_WRITE:
                begin
                    if (sent)
                    begin
                        state <= ST_DATA_ACK_WAIT;
                    end
                end
                ST_DATA_ACK_WAIT:
                begin
                    util <= grant;
                    if (grant)
                    begin
                        ack_buf <= sdi;
                        if (prefix == DATA_ACK_PATTERN)
                        begin
                            dvalid <= 1'b1;
                            busy   <= 1'b0;
                            state  <= ST_GRANTED;
                        end
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== verilog/serial_shifter.sv ====
`timescale 1ns/1ps

module serial_shifter (
    input  logic                              clk,
    input  logic                              rstn,
    input  bus_master_pkg::shift_ctrl_t       ctrl,
    input  logic                              sdi,
    output logic                              sdo,
    output logic                              sdo_en,
    output logic                              sent,
    output logic                              received,
    output logic [bus_master_pkg::DATA_WIDTH-1:0] rdata
);
    import bus_master_pkg::*;

    logic [ADDR_WIDTH-1:0] sreg;                             // Shared send/receive register
    logic [CNT_WIDTH-1:0]  cnt;                              // Bits left in the current phase
    logic [CNT_WIDTH-1:0]  phase_len;

    assign phase_len = ctrl.data_phase ? CNT_WIDTH'(DATA_WIDTH) : CNT_WIDTH'(ADDR_WIDTH);
    assign sdo       = sreg[ADDR_WIDTH-1];                   // MSB first
    assign received  = ctrl.capture && (cnt == CNT_WIDTH'(1)); // Last read bit this cycle

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            sdo_en <= 1'b0;
            sent   <= 1'b0;
            cnt    <= '0;
        end
        else
        begin
            sent <= 1'b0;
            if (ctrl.load)
            begin
                sdo_en <= 1'b1;                              // First bit shows next cycle
                cnt    <= phase_len;
            end
            else if (sdo_en)
            begin
                if (cnt == CNT_WIDTH'(1))
                begin
                    sdo_en <= 1'b0;                          // Last bit done
                    sent   <= 1'b1;
                end
                else
                begin
                    cnt <= cnt - 1'b1;
                end
            end
            else if (ctrl.capture)
            begin
                cnt <= cnt - 1'b1;
            end
            else
            begin
                cnt <= phase_len;                            // Ready for the next capture
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.load)
        begin
            sreg <= ctrl.word;
        end
        else if (sdo_en)
        begin
            sreg <= {sreg[ADDR_WIDTH-2:0], 1'b0};
        end
        else if (ctrl.capture)
        begin
            sreg <= {sreg[ADDR_WIDTH-2:0], sdi};
        end

        // Byte completes with the bit sampled on this edge
        if (received)
        begin
            rdata <= {sreg[DATA_WIDTH-2:0], sdi};
        end
    end

endmodule

// ==== verilog/bus_master_pkg.sv ====
package bus_master_pkg;

    localparam int DATA_WIDTH  = 8;                          // One data byte on the bus
    localparam int ADDR_WIDTH  = 15;                         // Slave address width
    localparam int TIMEOUT_LEN = 6;                          // Ack timeout counter, 64 cycles
    localparam int CNT_WIDTH   = $clog2(ADDR_WIDTH + 1);     // Shifter bit counter width

    localparam logic [1:0] ADDR_ACK_PATTERN = 2'b00;         // Address ack prefix
    localparam logic [1:0] DATA_ACK_PATTERN = 2'b01;         // Data ack / read start, older bit left

    typedef enum logic [3:0] {
        ST_IDLE          = 4'd0,
        ST_REQUESTED     = 4'd1,
        ST_GRANTED       = 4'd2,
        ST_ADDR_SEND     = 4'd3,
        ST_ADDR_ACK_WAIT = 4'd4,
        ST_TIMEOUT       = 4'd5,
        ST_READ_WAIT     = 4'd6,
        ST_READ_DATA     = 4'd7,
        ST_WRITE         = 4'd8,
        ST_DATA_ACK_WAIT = 4'd9
    } master_state_e;

    typedef struct packed {
        logic                  rw;                           // 1 is write
        logic [ADDR_WIDTH-1:0] address;
        logic [DATA_WIDTH-1:0] wdata;
    } master_cmd_t;

    typedef struct packed {
        logic request;
        logic utilizing;
        logic rw;
        logic sdo;
        logic sdo_en;
    } bus_drive_t;

    typedef struct packed {
        logic                  load;                         // Start a serial send
        logic                  data_phase;                   // Byte length instead of address length
        logic                  capture;                      // Shift sdi in while high
        logic [ADDR_WIDTH-1:0] word;
    } shift_ctrl_t;

endpackage
